// ==== uart_settings.svh ====
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// serial format, fixed at build time
`define UART_DATA_BITS    8                       // data bits per frame
`define UART_CLKS_PER_BIT 8                       // clock cycles per serial bit
`define UART_SYNC_STAGES  3                       // receive synchronizer depth

// start + data + parity + stop
`define UART_FRAME_BITS   (`UART_DATA_BITS + 3)

`endif

// ==== uart_pkg.sv ====
`include "uart_settings.svh"

package uart_pkg;

    // one payload byte
    typedef logic [`UART_DATA_BITS-1:0] uart_data_t;

    // frame as it appears on the line, lsb sent first
    typedef struct packed {
        logic       stop;                         // high when well formed
        logic       parity;                       // even parity over data
        uart_data_t data;                         // lsb first on the wire
        logic       start;                        // low when well formed
    } uart_frame_fields_t;

    // raw shift word in the sampler, named fields in the checker
    typedef union packed {
        logic [`UART_FRAME_BITS-1:0] raw;
        uart_frame_fields_t          f;
    } uart_frame_u;

    // received byte with its error flags
    typedef struct packed {
        uart_data_t data;
        logic       parity_err;                   // data ^ parity odd
        logic       frame_err;                    // stop bit read low
        logic       overrun;                      // a later frame was dropped
    } uart_rx_result_t;

endpackage

// ==== uart_tx.sv ====
`timescale 1ns/10ps
`include "uart_settings.svh"

module uart_tx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       i_valid,
    input  uart_data_t i_data,
    output logic       o_ready,
    output logic       o_serial
);

    localparam int CLK_W = $clog2(`UART_CLKS_PER_BIT);
    localparam int BIT_W = $clog2(`UART_FRAME_BITS);
    localparam logic [CLK_W-1:0] CLK_LAST = CLK_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`UART_FRAME_BITS - 1);

    logic                        busy_q;          // frame in flight
    logic [CLK_W-1:0]            clk_cnt_q;       // cycle within current bit
    logic [BIT_W-1:0]            bit_cnt_q;       // bit within frame
    logic [`UART_FRAME_BITS-1:0] shift_q;         // line driven from bit 0
    logic                        accept;
    logic                        parity;
    logic                        bit_end;
    logic                        frame_end;

    assign accept    = i_valid && o_ready;
    assign parity    = ^i_data;                   // even parity
    assign bit_end   = (clk_cnt_q == CLK_LAST);
    assign frame_end = bit_end && (bit_cnt_q == BIT_LAST);

    assign o_ready  = !busy_q;
    assign o_serial = shift_q[0];

    // busy flag and bit timing
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q    <= 1'b0;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else if (accept) begin
            busy_q    <= 1'b1;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else if (busy_q) begin
            if (bit_end) begin
                clk_cnt_q <= '0;
                if (frame_end) begin
                    busy_q <= 1'b0;               // ready again next cycle
                end else begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end
            end else begin
                clk_cnt_q <= clk_cnt_q + 1'b1;
            end
        end
    end

    // frame word, ones shifted in behind so the line idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_q <= '1;                        // idle line
        end else if (accept) begin
            shift_q <= {1'b1, parity, i_data, 1'b0};
        end else if (busy_q && bit_end && !frame_end) begin
            shift_q <= {1'b1, shift_q[`UART_FRAME_BITS-1:1]};
        end
    end

endmodule

// ==== uart_rx_sampler.sv ====
`timescale 1ns/10ps
`include "uart_settings.svh"

module uart_rx_sampler
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        i_serial,
    output logic        o_valid,
    output uart_frame_u o_frame,
    input  logic        i_ready
);

    localparam int CLK_W = $clog2(`UART_CLKS_PER_BIT);
    localparam int BIT_W = $clog2(`UART_FRAME_BITS);
    localparam logic [CLK_W-1:0] CLK_LAST  = CLK_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [CLK_W-1:0] HALF_LAST = CLK_W'(`UART_CLKS_PER_BIT / 2 - 1);
    localparam logic [BIT_W-1:0] BIT_LAST  = BIT_W'(`UART_FRAME_BITS - 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;      // waiting for a falling edge
    localparam logic [1:0] ST_START = 2'd1;      // half bit into the start bit
    localparam logic [1:0] ST_DATA  = 2'd2;      // sampling at mid-bit

    logic [`UART_SYNC_STAGES-1:0] sync_q;        // input synchronizer
    logic                         rx_bit;
    logic                         rx_prev_q;
    logic [1:0]                   state_q;
    logic [CLK_W-1:0]             clk_cnt_q;
    logic [BIT_W-1:0]             bit_cnt_q;     // bits taken so far
    uart_frame_u                  frame_q;
    logic                         valid_q;
    logic                         line_fall;
    logic                         start_mid;
    logic                         data_mid;
    logic                         last_bit;

    assign rx_bit    = sync_q[`UART_SYNC_STAGES-1];
    assign line_fall = rx_prev_q && !rx_bit;
    assign start_mid = (state_q == ST_START) && (clk_cnt_q == HALF_LAST);
    assign data_mid  = (state_q == ST_DATA) && (clk_cnt_q == CLK_LAST);
    assign last_bit  = (bit_cnt_q == BIT_LAST);

    assign o_valid = valid_q;
    assign o_frame = frame_q;

    // preset high so reset does not look like a start bit
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q    <= '1;
            rx_prev_q <= 1'b1;
        end else begin
            sync_q    <= {sync_q[`UART_SYNC_STAGES-2:0], i_serial};
            rx_prev_q <= rx_bit;
        end
    end

    // start detection and bit timing
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= ST_IDLE;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    clk_cnt_q <= '0;
                    if (line_fall) begin
                        state_q <= ST_START;
                    end
                end
                ST_START: begin
                    if (start_mid) begin
                        clk_cnt_q <= '0;
                        bit_cnt_q <= BIT_W'(1);  // start bit counts as taken
                        // glitch if the line is already back high
                        state_q   <= rx_bit ? ST_IDLE : ST_DATA;
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (data_mid) begin
                        clk_cnt_q <= '0;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (last_bit) begin
                            state_q <= ST_IDLE;  // stop bit sampled
                        end
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // bits enter at the msb, so the start bit ends up at bit 0
    always_ff @(posedge clk) begin
        if ((start_mid && !rx_bit) || data_mid) begin
            frame_q.raw <= {rx_bit, frame_q.raw[`UART_FRAME_BITS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (data_mid && last_bit) begin
            valid_q <= 1'b1;
        end else if (i_ready) begin
            valid_q <= 1'b0;                     // one cycle, checker never stalls
        end
    end

endmodule

// ==== uart_rx_checker.sv ====
`timescale 1ns/10ps

module uart_rx_checker
    import uart_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            i_valid,
    input  uart_frame_u     i_frame,
    output logic            o_ready,
    output logic            o_valid,
    output uart_rx_result_t o_result,
    input  logic            i_ready
);

    logic            valid_q;
    uart_rx_result_t result_q;
    logic            held;                        // result waiting on consumer
    logic            take;
    logic            parity_err;
    logic            frame_err;

    // a frame is either taken or dropped, never stalled
    assign o_ready = 1'b1;

    assign held       = valid_q && !i_ready;
    assign take       = i_valid && o_ready && !held;
    assign parity_err = ^{i_frame.f.data, i_frame.f.parity};
    assign frame_err  = !i_frame.f.stop;

    assign o_valid  = valid_q;
    assign o_result = result_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end else if (i_ready) begin
            valid_q <= 1'b0;                      // handshake done
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            result_q.data       <= i_frame.f.data;
            result_q.parity_err <= parity_err;
            result_q.frame_err  <= frame_err;
            result_q.overrun    <= 1'b0;
        end else if (i_valid && held) begin
            result_q.overrun    <= 1'b1;          // new frame dropped
        end
    end

endmodule

// ==== uart_top.sv ====
`timescale 1ns/10ps

module uart_top
    import uart_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            i_tx_valid,
    input  uart_data_t      i_tx_data,
    output logic            o_tx_ready,
    output logic            o_serial,
    input  logic            i_serial,
    output logic            o_rx_valid,
    output uart_rx_result_t o_rx,
    input  logic            i_rx_ready
);

    logic        s_frame_valid;                   // sampler to checker
    uart_frame_u s_frame;
    logic        s_frame_ready;

    uart_tx u_tx (
        .clk      (clk),
        .reset    (reset),
        .i_valid  (i_tx_valid),
        .i_data   (i_tx_data),
        .o_ready  (o_tx_ready),
        .o_serial (o_serial)
    );

    // serial loop is closed outside, in the testbench
    uart_rx_sampler u_rx_sampler (
        .clk      (clk),
        .reset    (reset),
        .i_serial (i_serial),
        .o_valid  (s_frame_valid),
        .o_frame  (s_frame),
        .i_ready  (s_frame_ready)
    );

    uart_rx_checker u_rx_checker (
        .clk      (clk),
        .reset    (reset),
        .i_valid  (s_frame_valid),
        .i_frame  (s_frame),
        .o_ready  (s_frame_ready),
        .o_valid  (o_rx_valid),
        .o_result (o_rx),
        .i_ready  (i_rx_ready)
    );

endmodule

// ==== uart_props.sv ====
`timescale 1ns/10ps

module uart_props
    import uart_pkg::*;
(
    input logic            clk,
    input logic            reset,
    input logic            i_tx_valid,
    input logic            o_tx_ready,
    input logic            o_serial,
    input logic            o_rx_valid,
    input uart_rx_result_t o_rx,
    input logic            i_rx_ready
);

    // held result keeps byte and flags, overrun may only rise
    property rx_held_stable;
        @(posedge clk) disable iff (reset)
            (o_rx_valid && !i_rx_ready) |=>
                o_rx_valid && $stable(o_rx.data) && $stable(o_rx.parity_err) &&
                $stable(o_rx.frame_err) && (o_rx.overrun || !$past(o_rx.overrun));
    endproperty

    property idle_line_high;
        @(posedge clk) disable iff (reset)
            o_tx_ready |-> o_serial;
    endproperty

    property busy_after_accept;
        @(posedge clk) disable iff (reset)
            (i_tx_valid && o_tx_ready) |=> !o_tx_ready;
    endproperty

    a_rx_held: assert property (rx_held_stable)
        else $error("o_rx changed while the result was held");

    a_idle_high: assert property (idle_line_high)
        else $error("o_serial low while the transmitter is idle");

    a_tx_busy: assert property (busy_after_accept)
        else $error("o_tx_ready still high after a byte was accepted");

endmodule

bind uart_top uart_props u_props (
    .clk        (clk),
    .reset      (reset),
    .i_tx_valid (i_tx_valid),
    .o_tx_ready (o_tx_ready),
    .o_serial   (o_serial),
    .o_rx_valid (o_rx_valid),
    .o_rx       (o_rx),
    .i_rx_ready (i_rx_ready)
);

// ==== tb_uart.sv ====
`timescale 1ns/10ps
`include "uart_settings.svh"

module tb_uart
    import uart_pkg::*;
();

    localparam int CPB          = `UART_CLKS_PER_BIT;
    localparam int FRAME_CYCLES = `UART_FRAME_BITS * CPB;
    localparam int NUM_DIRECTED = 8;
    localparam int NUM_RANDOM   = 12;
    localparam int NUM_TESTS    = NUM_DIRECTED + NUM_RANDOM;
    localparam int TIMEOUT      = NUM_TESTS * 200;
    localparam int DRAIN_LIMIT  = 500;

    typedef struct packed {
        uart_data_t  data;
        logic        flip_par;                    // invert parity bit on the line
        logic        flip_stop;                   // invert stop bit on the line
        logic [15:0] hold;                        // cycles i_rx_ready stays low
        logic        b2b;                         // no wait for the receive side
        logic        drop;                        // lands while previous result held
    } stim_t;

    typedef struct packed {
        uart_rx_result_t res;
        logic [15:0]     hold;
        logic [7:0]      idx;
    } expect_t;

    logic            clk = 1'b0;
    logic            reset;
    logic            i_tx_valid;
    uart_data_t      i_tx_data;
    logic            o_tx_ready;
    logic            o_serial;
    logic            i_serial;
    logic            o_rx_valid;
    uart_rx_result_t o_rx;
    logic            i_rx_ready;
    logic            inject;                      // corrupts the looped line

    stim_t       stim [NUM_TESTS];
    expect_t     exp_q [$];                       // results still owed by the DUT
    int          errors = 0;
    int          cycle_count = 0;
    logic [31:0] rand_state = 32'd85;

    assign i_serial = o_serial ^ inject;          // loopback outside the DUT

    uart_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .i_tx_valid (i_tx_valid),
        .i_tx_data  (i_tx_data),
        .o_tx_ready (o_tx_ready),
        .o_serial   (o_serial),
        .i_serial   (i_serial),
        .o_rx_valid (o_rx_valid),
        .o_rx       (o_rx),
        .i_rx_ready (i_rx_ready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_result(input string name, input uart_rx_result_t exp,
                                input uart_rx_result_t got);
        if (got !== exp) begin
            $display("ERR %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input uart_data_t exp, input uart_data_t got);
        if (got !== exp) begin
            $display("ERR %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("ERR %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic fill_table();
        //          data   par   stop  hold    b2b   drop
        stim[0] = '{8'h55, 1'b0, 1'b0, 16'd0,   1'b0, 1'b0};
        stim[1] = '{8'hA3, 1'b0, 1'b0, 16'd3,   1'b0, 1'b0};
        stim[2] = '{8'h3C, 1'b1, 1'b0, 16'd0,   1'b0, 1'b0};
        stim[3] = '{8'hC7, 1'b0, 1'b1, 16'd0,   1'b0, 1'b0};
        stim[4] = '{8'h0F, 1'b1, 1'b1, 16'd1,   1'b0, 1'b0};
        stim[5] = '{8'h96, 1'b0, 1'b0, 16'd250, 1'b0, 1'b0};
        stim[6] = '{8'h6E, 1'b0, 1'b0, 16'd300, 1'b0, 1'b0};
        stim[7] = '{8'h81, 1'b0, 1'b0, 16'd0,   1'b1, 1'b1};
        for (int i = NUM_DIRECTED; i < NUM_TESTS; i++) begin
            rand_state = next_random(rand_state);
            stim[i] = '{rand_state[`UART_DATA_BITS-1:0], 1'b0, 1'b0, 16'd0,
                        (i != NUM_DIRECTED), 1'b0};
        end
    endtask

    function automatic expect_t expected_for(input int i);
        expect_t e;
        e.res.data       = stim[i].data;
        e.res.parity_err = stim[i].flip_par;
        e.res.frame_err  = stim[i].flip_stop;
        e.res.overrun    = (i + 1 < NUM_TESTS) && stim[i+1].drop;  // next one gets lost
        e.hold           = stim[i].hold;
        e.idx            = 8'(i);
        return e;
    endfunction

    // send one frame with chosen bits corrupted and sample each bit at its middle
    task automatic send_frame(input stim_t s, output uart_frame_u seen);
        int bit_idx;
        while (o_tx_ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        i_tx_valid = 1'b1;
        i_tx_data  = s.data;
        @(posedge clk);                           // accepted here
        #1;
        i_tx_valid = 1'b0;
        for (int c = 0; c < FRAME_CYCLES; c++) begin
            bit_idx = c / CPB;
            inject  = (s.flip_par && bit_idx == `UART_DATA_BITS + 1) ||
                      (s.flip_stop && bit_idx == `UART_DATA_BITS + 2);
            if (c % CPB == CPB / 2) begin
                seen.raw[bit_idx] = o_serial;
            end
            @(posedge clk);
            #1;
        end
        inject = 1'b0;
    endtask

    task automatic check_shape(input stim_t s, input uart_frame_u seen);
        check_level("o_serial start", 1'b0, seen.f.start);
        check_data("o_serial data", s.data, seen.f.data);
        // parity bit set when the data holds an odd number of ones
        check_level("o_serial parity", ($countones(s.data) % 2) != 0, seen.f.parity);
        check_level("o_serial stop", 1'b1, seen.f.stop);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        while (exp_q.size() != 0) begin
            $display("test %0d: no result arrived on o_rx", exp_q[0].idx);
            errors++;
            void'(exp_q.pop_front());
        end
    endtask

    // consumer of o_rx that holds ready low as the table asks
    initial begin : rx_consumer
        expect_t         e;
        uart_rx_result_t held_res;
        int              errs_before;
        i_rx_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (o_rx_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected result on o_rx with data %h", o_rx.data);
                    errors++;
                end else begin
                    e           = exp_q[0];
                    held_res    = o_rx;
                    errs_before = errors;
                    if (e.hold != 0) begin
                        i_rx_ready = 1'b0;
                        repeat (e.hold) begin
                            @(posedge clk);
                            #1;
                            check_level("o_rx_valid", 1'b1, o_rx_valid);
                            check_data("o_rx.data", held_res.data, o_rx.data);
                            check_level("o_rx.parity_err", held_res.parity_err, o_rx.parity_err);
                            check_level("o_rx.frame_err", held_res.frame_err, o_rx.frame_err);
                        end
                        i_rx_ready = 1'b1;
                    end
                    check_result("o_rx", e.res, o_rx);
                    $display("test %0d: byte %h flags %b %s", e.idx, o_rx.data,
                             o_rx[2:0], (errors == errs_before) ? "ok" : "mismatch");
                    void'(exp_q.pop_front());
                end
            end
        end
    end

    initial begin : main_seq
        uart_frame_u seen;
        reset      = 1'b1;
        i_tx_valid = 1'b0;
        i_tx_data  = '0;
        inject     = 1'b0;
        fill_table();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_level("o_tx_ready", 1'b1, o_tx_ready);
        check_level("o_serial", 1'b1, o_serial);
        check_level("o_rx_valid", 1'b0, o_rx_valid);
        $display("reset state checked");
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (!stim[i].b2b) begin
                wait_drain();
            end
            if (stim[i].drop) begin
                $display("test %0d: byte %h sent while a result is held", i, stim[i].data);
            end else begin
                exp_q.push_back(expected_for(i));
            end
            send_frame(stim[i], seen);
            check_shape(stim[i], seen);
        end
        wait_drain();
        repeat (2 * FRAME_CYCLES) @(posedge clk);  // a dropped byte must stay gone
        $display("%0d tests run, %0d errors", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
uart_pkg.sv
uart_tx.sv
uart_rx_sampler.sv
uart_rx_checker.sv
uart_top.sv
uart_props.sv
tb_uart.sv

// ==== Bender.yml ====
package:
  name: uart

sources:
  - include_dirs:
      - .
    files:
      - uart_pkg.sv
      - uart_tx.sv
      - uart_rx_sampler.sv
      - uart_rx_checker.sv
      - uart_top.sv

  - target: test
    include_dirs:
      - .
    files:
      - uart_props.sv
      - tb_uart.sv
